//--- design/game_rom_pkg.sv
// Shared constants and types for the game ROM path.
// Download and fetch logic refer to these by scoped names.
// Region offsets are byte offsets inside the loaded ROM image.

package game_rom_pkg;

    // SDRAM port
    localparam int SDRAM_AW = 22;

    // One SDRAM data word, two byte lanes
    typedef logic [15:0] sdram_word_t;

    // Loader byte stream
    localparam int IOCTL_AW = 25;

    // Image layout
    //   0x00000  main CPU code
    //   SCR      scroll tiles, 32-bit fetches
    //   OBJ      object tiles, 32-bit fetches
    //   PCM      end of the graphics data
    //   PROM     colour PROMs, kept out of SDRAM
    localparam logic [SDRAM_AW-1:0] SCR_START = 22'h0_8000;
    localparam logic [SDRAM_AW-1:0] OBJ_START = 22'h1_0000;
    localparam logic [SDRAM_AW-1:0] PCM_START = 22'h1_8000;

    // PROM region starts where the graphics end in this layout
    localparam logic [IOCTL_AW-1:0] PROM_START = 25'h1_8000;

    // PROM write port, 2 kB of colour data
    localparam int PROM_AW = 11;

endpackage

//--- design/rom_dwnld.sv
// ROM download unit. Turns loader bytes into SDRAM word writes,
// reorders the graphics address bits for the video fetch layout,
// sends colour-PROM bytes to the PROM port and keeps the board flag.
`timescale 1ns/1ps

module rom_dwnld #(
    parameter logic [game_rom_pkg::SDRAM_AW-1:0] SCR_START  = game_rom_pkg::SCR_START,
    parameter logic [game_rom_pkg::SDRAM_AW-1:0] OBJ_START  = game_rom_pkg::OBJ_START,
    parameter logic [game_rom_pkg::SDRAM_AW-1:0] PCM_START  = game_rom_pkg::PCM_START,
    parameter logic [game_rom_pkg::IOCTL_AW-1:0] PROM_START = game_rom_pkg::PROM_START
) (
    input  logic                                clk,
    input  logic                                rst_n,
    // Loader byte stream
    input  logic                                downloading,
    input  logic [game_rom_pkg::IOCTL_AW-1:0]   ioctl_addr,
    input  logic [7:0]                          ioctl_dout,
    input  logic                                ioctl_wr,
    // SDRAM programming
    output logic [game_rom_pkg::SDRAM_AW-1:0]   prog_addr,
    output game_rom_pkg::sdram_word_t           prog_data,
    output logic [1:0]                          prog_mask,
    output logic                                prog_we,
    // Colour PROM programming
    output logic [game_rom_pkg::PROM_AW-1:0]    prom_addr,
    output logic [7:0]                          prom_data,
    output logic                                prom_we,
    // Board variant
    output logic                                alt_map
);

    localparam int SAW = game_rom_pkg::SDRAM_AW;
    localparam int IAW = game_rom_pkg::IOCTL_AW;

    // Byte that selects the alternative graphics mapping
    localparam logic [IAW-1:0] FLAG_ADDR = PROM_START + 25'd1;

    logic [SAW-1:0] byte_addr;
    logic [SAW-1:0] word_addr;
    logic [SAW-1:0] swz_addr;
    logic [IAW-1:0] prom_offset;
    logic           is_scr;
    logic           is_obj;
    logic           is_prom;
    logic           wr_en;

    assign wr_en = ioctl_wr & downloading;

    // Region decode on the byte address
    assign byte_addr = ioctl_addr[SAW-1:0];
    assign is_scr    = (byte_addr >= SCR_START) && (byte_addr < OBJ_START);
    assign is_obj    = (byte_addr >= OBJ_START) && (byte_addr < PCM_START);
    assign is_prom   = ioctl_addr >= PROM_START;

    // Two bytes share one SDRAM word
    assign word_addr   = ioctl_addr[SAW:1];
    assign prom_offset = ioctl_addr - PROM_START;

    // Tile rows are interleaved so that one burst holds a whole row
    always_comb begin
        swz_addr = word_addr;
        if (is_scr) begin
            swz_addr[3:0] = {word_addr[2:0], ~word_addr[3]};
        end else if (is_obj) begin
            swz_addr[4:0] = {word_addr[2:0], ~word_addr[4], ~word_addr[3]};
        end
    end

    // Write strobes and the variant flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
            alt_map <= 1'b0;
        end else begin
            prog_we <= wr_en & ~is_prom;
            prom_we <= wr_en & is_prom;
            if (wr_en && ioctl_addr == FLAG_ADDR) begin
                alt_map <= &ioctl_dout;
            end
        end
    end

    // Write payload, valid alongside the strobes
    always_ff @(posedge clk) begin
        if (wr_en) begin
            prog_addr <= swz_addr;
            prog_data <= {2{ioctl_dout}};
            // Active low, even bytes land in the upper lane
            prog_mask <= ioctl_addr[0] ? 2'b10 : 2'b01;
            prom_addr <= prom_offset[game_rom_pkg::PROM_AW-1:0];
            prom_data <= ioctl_dout;
        end
    end

endmodule

//--- design/rom_slot.sv
// Single ROM fetch slot with a one-entry cache.
// A miss issues one SDRAM request and assembles the returned beats,
// upper word first. An 8-bit payload keeps the whole word and picks a byte.
`timescale 1ns/1ps

module rom_slot #(
    parameter type payload_t = logic [31:0],
    parameter int AW = 13,
    parameter logic [game_rom_pkg::SDRAM_AW-1:0] OFFSET = '0
) (
    input  logic                                clk,
    input  logic                                rst_n,
    // Client side
    input  logic                                cs,
    input  logic [AW-1:0]                       addr,
    output payload_t                            dout,
    output logic                                ok,
    // Request to the arbiter
    output logic                                req_valid,
    output logic [game_rom_pkg::SDRAM_AW-1:0]   req_addr,
    input  logic                                req_ready,
    // Returned beats
    input  logic                                beat_valid,
    input  game_rom_pkg::sdram_word_t           beat_data,
    input  logic                                beat_last
);

    localparam int SAW   = game_rom_pkg::SDRAM_AW;
    localparam int DW    = $bits(payload_t);
    localparam int NBEAT = (DW > 16) ? DW / 16 : 1;
    localparam int BUF_W = NBEAT * 16;
    localparam int CW    = $clog2(NBEAT + 1);

    logic [AW-1:0]    cur_tag;
    logic [AW-1:0]    tag_q;
    logic [AW-1:0]    pend_tag;
    logic             tag_valid;
    logic             wait_q;
    logic [BUF_W-1:0] buf_q;
    logic [CW-1:0]    beat_cnt;
    logic [SAW-1:0]   word_addr;
    logic             hit;
    logic             start;
    logic             take;
    logic             done;

    // Byte slots cache a whole word, so the tag drops the lane bit
    assign cur_tag   = (DW <= 8) ? (addr >> 1) : addr;
    assign word_addr = OFFSET + SAW'(cur_tag * NBEAT);

    assign hit = tag_valid && (tag_q == cur_tag);
    assign ok  = cs && hit;

    assign start = !req_valid && !wait_q && cs && !hit;
    // Extra beats of a longer burst are dropped
    assign take  = wait_q && beat_valid && (beat_cnt < NBEAT);
    assign done  = wait_q && beat_valid && beat_last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
            wait_q    <= 1'b0;
            tag_valid <= 1'b0;
            beat_cnt  <= '0;
        end else begin
            if (start) begin
                req_valid <= 1'b1;
                tag_valid <= 1'b0;
                beat_cnt  <= '0;
            end
            if (req_valid && req_ready) begin
                req_valid <= 1'b0;
                wait_q    <= 1'b1;
            end
            if (take) begin
                beat_cnt <= CW'(beat_cnt + 1'b1);
            end
            if (done) begin
                wait_q    <= 1'b0;
                tag_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_addr <= word_addr;
            pend_tag <= cur_tag;
        end
        if (take) begin
            buf_q <= BUF_W'({buf_q, beat_data});
        end
        if (done) begin
            tag_q <= pend_tag;
        end
    end

    generate
        if (DW <= 8) begin : g_byte
            // Even byte sits in the upper lane
            assign dout = payload_t'(addr[0] ? buf_q[7:0] : buf_q[15:8]);
        end else begin : g_word
            assign dout = payload_t'(buf_q[DW-1:0]);
        end
    endgenerate

endmodule

//--- design/rom_arbiter.sv
// Fixed-priority arbiter in front of the shared SDRAM read port.
// Slot 0 has the highest priority. One transaction is in flight at a time
// and the returned beats are steered to the slot that owns it.
`timescale 1ns/1ps

module rom_arbiter #(
    parameter int NSLOT = 3
) (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            downloading,
    // Slot requests
    input  logic [NSLOT-1:0]                                req_valid,
    input  logic [NSLOT-1:0][game_rom_pkg::SDRAM_AW-1:0]    req_addr,
    output logic [NSLOT-1:0]                                req_ready,
    // Beats back to the slots
    output logic [NSLOT-1:0]                                beat_valid,
    output game_rom_pkg::sdram_word_t                       beat_data,
    output logic                                            beat_last,
    // SDRAM port
    output logic                                            sdram_req,
    output logic [game_rom_pkg::SDRAM_AW-1:0]               sdram_addr,
    input  logic                                            sdram_ack,
    input  game_rom_pkg::sdram_word_t                       data_read,
    input  logic                                            data_dst,
    input  logic                                            data_rdy
);

    localparam int SAW = game_rom_pkg::SDRAM_AW;

    logic             busy;
    logic [NSLOT-1:0] owner;
    logic [NSLOT-1:0] pick;
    logic [SAW-1:0]   sel_addr;
    logic             grant_en;
    logic             launch;

    // Lowest requesting index wins
    always_comb begin
        pick = '0;
        for (int i = 0; i < NSLOT; i++) begin
            if (req_valid[i] && pick == '0) begin
                pick[i] = 1'b1;
            end
        end
    end

    always_comb begin
        sel_addr = '0;
        for (int i = 0; i < NSLOT; i++) begin
            if (pick[i]) begin
                sel_addr = req_addr[i];
            end
        end
    end

    // The SDRAM belongs to the loader while downloading
    assign grant_en  = !busy && !downloading;
    assign launch    = grant_en && (pick != '0);
    assign req_ready = {NSLOT{grant_en}} & pick;

    // Beats only count once the request has been acknowledged
    assign beat_valid = {NSLOT{busy & ~sdram_req & data_dst}} & owner;
    assign beat_data  = data_read;
    assign beat_last  = data_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            sdram_req <= 1'b0;
            owner     <= '0;
        end else if (launch) begin
            busy      <= 1'b1;
            sdram_req <= 1'b1;
            owner     <= pick;
        end else if (busy) begin
            if (sdram_req && sdram_ack) begin
                sdram_req <= 1'b0;
            end
            if (!sdram_req && data_rdy) begin
                busy  <= 1'b0;
                owner <= '0;
            end
        end
    end

    // Address stays put until the next grant
    always_ff @(posedge clk) begin
        if (launch) begin
            sdram_addr <= sel_addr;
        end
    end

endmodule

//--- design/game_rom_top.sv
// ROM path of the game core. Download unit on the loader side, three
// cached fetch slots (scroll, object, main CPU) sharing one SDRAM port.
`timescale 1ns/1ps

module game_rom_top #(
    parameter logic [game_rom_pkg::SDRAM_AW-1:0] SCR_START  = game_rom_pkg::SCR_START,
    parameter logic [game_rom_pkg::SDRAM_AW-1:0] OBJ_START  = game_rom_pkg::OBJ_START,
    parameter logic [game_rom_pkg::SDRAM_AW-1:0] PCM_START  = game_rom_pkg::PCM_START,
    parameter logic [game_rom_pkg::IOCTL_AW-1:0] PROM_START = game_rom_pkg::PROM_START,
    parameter int SCR_AW  = 13,
    parameter int OBJ_AW  = 13,
    parameter int MAIN_AW = 15
) (
    input  logic                                clk,
    input  logic                                rst_n,
    // Loader
    input  logic                                downloading,
    input  logic [game_rom_pkg::IOCTL_AW-1:0]   ioctl_addr,
    input  logic [7:0]                          ioctl_dout,
    input  logic                                ioctl_wr,
    // SDRAM programming
    output logic [game_rom_pkg::SDRAM_AW-1:0]   prog_addr,
    output game_rom_pkg::sdram_word_t           prog_data,
    output logic [1:0]                          prog_mask,
    output logic                                prog_we,
    // Colour PROMs
    output logic [game_rom_pkg::PROM_AW-1:0]    prom_addr,
    output logic [7:0]                          prom_data,
    output logic                                prom_we,
    // SDRAM read port
    output logic                                sdram_req,
    output logic [game_rom_pkg::SDRAM_AW-1:0]   sdram_addr,
    input  logic                                sdram_ack,
    input  game_rom_pkg::sdram_word_t           data_read,
    input  logic                                data_dst,
    input  logic                                data_rdy,
    // Scroll tiles
    input  logic                                scr_cs,
    input  logic [SCR_AW-1:0]                   scr_addr,
    output logic [31:0]                         scr_data,
    output logic                                scr_ok,
    // Object tiles
    input  logic                                obj_cs,
    input  logic [OBJ_AW-1:0]                   obj_addr,
    output logic [31:0]                         obj_data,
    output logic                                obj_ok,
    // Main CPU
    input  logic                                main_cs,
    input  logic [MAIN_AW-1:0]                  main_addr,
    output logic [7:0]                          main_data,
    output logic                                main_ok,
    output logic                                alt_map
);

    localparam int SAW = game_rom_pkg::SDRAM_AW;

    // Index is the arbiter priority, 0 first
    logic [2:0]          req_valid;
    logic [2:0][SAW-1:0] req_addr;
    logic [2:0]          req_ready;
    logic [2:0]          beat_valid;
    game_rom_pkg::sdram_word_t beat_data;
    logic                beat_last;

    rom_dwnld #(
        .SCR_START  (SCR_START),
        .OBJ_START  (OBJ_START),
        .PCM_START  (PCM_START),
        .PROM_START (PROM_START)
    ) u_dwnld (
        .clk (clk), .rst_n (rst_n), .downloading (downloading),
        .ioctl_addr (ioctl_addr), .ioctl_dout (ioctl_dout), .ioctl_wr (ioctl_wr),
        .prog_addr (prog_addr), .prog_data (prog_data),
        .prog_mask (prog_mask), .prog_we (prog_we),
        .prom_addr (prom_addr), .prom_data (prom_data), .prom_we (prom_we),
        .alt_map (alt_map)
    );

    // Slot offsets are in SDRAM words
    rom_slot #(.payload_t(logic [31:0]), .AW(SCR_AW), .OFFSET(SCR_START >> 1)) u_scr (
        .clk (clk), .rst_n (rst_n),
        .cs (scr_cs), .addr (scr_addr), .dout (scr_data), .ok (scr_ok),
        .req_valid (req_valid[0]), .req_addr (req_addr[0]), .req_ready (req_ready[0]),
        .beat_valid (beat_valid[0]), .beat_data (beat_data), .beat_last (beat_last)
    );

    rom_slot #(.payload_t(logic [31:0]), .AW(OBJ_AW), .OFFSET(OBJ_START >> 1)) u_obj (
        .clk (clk), .rst_n (rst_n),
        .cs (obj_cs), .addr (obj_addr), .dout (obj_data), .ok (obj_ok),
        .req_valid (req_valid[1]), .req_addr (req_addr[1]), .req_ready (req_ready[1]),
        .beat_valid (beat_valid[1]), .beat_data (beat_data), .beat_last (beat_last)
    );

    // Main CPU code starts at the bottom of the image
    rom_slot #(.payload_t(logic [7:0]), .AW(MAIN_AW), .OFFSET('0)) u_main (
        .clk (clk), .rst_n (rst_n),
        .cs (main_cs), .addr (main_addr), .dout (main_data), .ok (main_ok),
        .req_valid (req_valid[2]), .req_addr (req_addr[2]), .req_ready (req_ready[2]),
        .beat_valid (beat_valid[2]), .beat_data (beat_data), .beat_last (beat_last)
    );

    rom_arbiter #(.NSLOT(3)) u_arb (
        .clk (clk), .rst_n (rst_n), .downloading (downloading),
        .req_valid (req_valid), .req_addr (req_addr), .req_ready (req_ready),
        .beat_valid (beat_valid), .beat_data (beat_data), .beat_last (beat_last),
        .sdram_req (sdram_req), .sdram_addr (sdram_addr), .sdram_ack (sdram_ack),
        .data_read (data_read), .data_dst (data_dst), .data_rdy (data_rdy)
    );

endmodule

//--- test/sdram_model.sv
// Behavioural SDRAM for the ROM path testbench. Stores programming writes
// and answers each read request with a two-word burst after a random delay.
`timescale 1ns/1ps

module sdram_model (
    input  logic                                clk,
    input  logic [game_rom_pkg::SDRAM_AW-1:0]   prog_addr,
    input  game_rom_pkg::sdram_word_t           prog_data,
    input  logic [1:0]                          prog_mask,
    input  logic                                prog_we,
    input  logic                                sdram_req,
    input  logic [game_rom_pkg::SDRAM_AW-1:0]   sdram_addr,
    output logic                                sdram_ack,
    output game_rom_pkg::sdram_word_t           data_read,
    output logic                                data_dst,
    output logic                                data_rdy
);

    game_rom_pkg::sdram_word_t mem [0:65535];
    logic [31:0] lfsr = 32'h34dd;

    // Fibonacci form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Mask is active low, one bit per lane
    always @(posedge clk) begin
        if (prog_we && !prog_mask[1]) begin
            mem[prog_addr[15:0]][15:8] <= prog_data[15:8];
        end
        if (prog_we && !prog_mask[0]) begin
            mem[prog_addr[15:0]][7:0] <= prog_data[7:0];
        end
    end

    initial begin
        logic [15:0] base;
        logic [1:0]  extra;
        sdram_ack = 1'b0;
        data_dst  = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge clk);
            #2;
            if (sdram_req) begin
                base = sdram_addr[15:0];
                for (int i = 0; i < 2; i++) begin
                    lfsr     = lfsr_next(lfsr);
                    extra[i] = lfsr[0];
                end
                // Acknowledge 1 to 4 cycles later
                repeat (int'(extra) + 1) @(posedge clk);
                #2 sdram_ack = 1'b1;
                @(posedge clk);
                #2 sdram_ack = 1'b0;
                data_dst  = 1'b1;
                data_read = mem[base];
                @(posedge clk);
                #2 data_read = mem[base + 16'd1];
                data_rdy  = 1'b1;
                @(posedge clk);
                #2 data_dst = 1'b0;
                data_rdy  = 1'b0;
            end
        end
    end

endmodule

//--- test/game_rom_properties.sv
// Protocol checks on the ROM path top level.
// Bound into every game_rom_top instance.
`timescale 1ns/1ps

module game_rom_properties (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                downloading,
    input  logic                                prog_we,
    input  logic                                prom_we,
    input  logic                                sdram_req,
    input  logic                                sdram_ack,
    input  logic [game_rom_pkg::SDRAM_AW-1:0]   sdram_addr
);

    // Count of failed properties
    int fail_count = 0;

    // Request and address stay put until acknowledged
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr))
        else begin
            $error("sdram_req dropped or sdram_addr changed before sdram_ack");
            fail_count++;
        end

    write_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(prog_we && prom_we))
        else begin
            $error("prog_we and prom_we high in the same cycle");
            fail_count++;
        end

    // SDRAM belongs to the loader during download
    no_req_dl: assert property (@(posedge clk) disable iff (!rst_n)
        downloading |-> !sdram_req)
        else begin
            $error("sdram_req raised while downloading");
            fail_count++;
        end

endmodule

bind game_rom_top game_rom_properties u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .downloading (downloading),
    .prog_we     (prog_we),
    .prom_we     (prom_we),
    .sdram_req   (sdram_req),
    .sdram_ack   (sdram_ack),
    .sdram_addr  (sdram_addr)
);

//--- test/tb_game_rom.sv
// Testbench for the game ROM path. Downloads bytes from a table, checks
// the SDRAM and PROM write ports, then fetches through each slot and
// compares against a byte image kept here.
`timescale 1ns/1ps

module tb_game_rom;

    localparam int          SAW         = game_rom_pkg::SDRAM_AW;
    localparam int          SCR_W       = game_rom_pkg::SCR_START >> 1;
    localparam int          OBJ_W       = game_rom_pkg::OBJ_START >> 1;
    localparam int          RST_CYC     = 2;
    localparam int          CYC_PER_ROW = 60;
    localparam logic [31:0] NO_REQ      = 32'hFFFF_FFFF;

    // BOTH fetches scroll at addr and main at data
    typedef enum {WR, SCR, OBJ, MAIN, BOTH} kind_t;
    typedef struct {
        string       name;
        kind_t       kind;
        logic [24:0] addr;
        logic [7:0]  data;
        logic [31:0] exp;
    } row_t;

    logic clk, rst_n, downloading, ioctl_wr, prog_we, prom_we, alt_map;
    logic sdram_req, sdram_ack, data_dst, data_rdy;
    logic scr_cs, scr_ok, obj_cs, obj_ok, main_cs, main_ok;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_dout, prom_data, main_data;
    logic [SAW-1:0] prog_addr, sdram_addr;
    logic [1:0]  prog_mask;
    logic [10:0] prom_addr;
    logic [12:0] scr_addr, obj_addr;
    logic [14:0] main_addr;
    logic [31:0] scr_data, obj_data;
    game_rom_pkg::sdram_word_t prog_data, data_read;

    // SDRAM byte image indexed by word address and lane (lane 0 is upper)
    logic [7:0]     image [0:(1 << 18) - 1];
    logic [SAW-1:0] req_log [$];
    logic           req_q = 1'b0;
    logic           alt_exp = 1'b0;
    row_t           rows [$];
    int             cycles = 0;

    game_rom_top u_dut (.*);
    sdram_model u_sdram (.*);

    always #20 clk = ~clk;

    // Log the address of every new SDRAM request
    always @(posedge clk) begin
        if (sdram_req && !req_q) begin
            req_log.push_back(sdram_addr);
        end
        req_q <= sdram_req;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYC_PER_ROW * rows.size() + RST_CYC) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("Test FAILED");
            $fatal(1, "run stopped by timeout");
        end
    end

    // Stop at the first failed bound property
    always @(posedge clk) begin
        if (u_dut.u_props.fail_count != 0) begin
            $display("A bound protocol assertion failed, see the error above");
            $display("Test FAILED");
            $fatal(1, "run stopped by a protocol assertion");
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            $display("Test FAILED");
            $fatal(1, "run stopped at first error");
        end
    endtask

    task automatic add_row(input string name, input kind_t kind, input logic [24:0] addr,
                           input logic [7:0] data, input logic [31:0] exp);
        rows.push_back('{name, kind, addr, data, exp});
    endtask

    function automatic logic [15:0] word_at(input int w);
        return {image[2 * w], image[2 * w + 1]};
    endfunction

    function automatic logic all_ok();
        return (scr_ok || !scr_cs) && (obj_ok || !obj_cs) && (main_ok || !main_cs);
    endfunction

    // exp is the prog word address, or prom_addr for the PROM region
    task automatic write_byte(input row_t r);
        logic prom;
        prom = r.addr >= game_rom_pkg::PROM_START;
        @(posedge clk);
        #2;
        ioctl_addr = r.addr;
        ioctl_dout = r.data;
        ioctl_wr   = 1'b1;
        @(posedge clk);
        #2;
        ioctl_wr = 1'b0;
        check_value({r.name, "/prog_we"}, !prom, prog_we);
        check_value({r.name, "/prom_we"}, prom, prom_we);
        if (prom) begin
            if (r.addr == game_rom_pkg::PROM_START + 1) begin
                alt_exp = &r.data;
            end
            check_value({r.name, "/prom_addr"}, r.exp, prom_addr);
            check_value({r.name, "/prom_data"}, r.data, prom_data);
            check_value({r.name, "/alt_map"}, alt_exp, alt_map);
        end else begin
            image[{r.exp[16:0], r.addr[0]}] = r.data;
            check_value({r.name, "/prog_addr"}, r.exp, prog_addr);
            check_value({r.name, "/prog_mask"}, r.addr[0] ? 2'b10 : 2'b01, prog_mask);
            check_value({r.name, "/prog_data"}, {2{r.data}}, prog_data);
        end
        @(posedge clk);
    endtask

    // exp is the first new sdram_addr, or NO_REQ for a cache hit
    task automatic fetch_slot(input row_t r);
        int   n_before;
        int   w;
        logic hit_now;
        n_before = req_log.size();
        @(posedge clk);
        #2;
        scr_cs    = (r.kind == SCR || r.kind == BOTH);
        obj_cs    = (r.kind == OBJ);
        main_cs   = (r.kind == MAIN || r.kind == BOTH);
        scr_addr  = r.addr[12:0];
        obj_addr  = r.addr[12:0];
        main_addr = (r.kind == BOTH) ? 15'(r.data) : r.addr[14:0];
        #1;
        hit_now = all_ok();
        // Requests raised during the download wait until the loader lets go
        if (downloading) begin
            repeat (3) @(posedge clk);
            #2;
            check_value({r.name, "/req_in_download"}, 0, sdram_req);
            downloading = 1'b0;
        end
        while (!all_ok()) begin
            @(posedge clk);
            #3;
        end
        if (scr_cs) begin
            w = SCR_W + 2 * int'(r.addr);
            check_value({r.name, "/scr_data"}, {word_at(w), word_at(w + 1)}, scr_data);
        end
        if (obj_cs) begin
            w = OBJ_W + 2 * int'(r.addr);
            check_value({r.name, "/obj_data"}, {word_at(w), word_at(w + 1)}, obj_data);
        end
        if (main_cs) begin
            check_value({r.name, "/main_data"}, image[main_addr], main_data);
        end
        if (r.exp == NO_REQ) begin
            check_value({r.name, "/hit"}, 1, hit_now);
            check_value({r.name, "/req_count"}, n_before, req_log.size());
        end else begin
            check_value({r.name, "/first_req"}, r.exp, req_log[n_before]);
        end
        scr_cs  = 1'b0;
        obj_cs  = 1'b0;
        main_cs = 1'b0;
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        downloading = 1'b1;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        scr_cs      = 1'b0;
        obj_cs      = 1'b0;
        main_cs     = 1'b0;
        scr_addr    = '0;
        obj_addr    = '0;
        main_addr   = '0;
        add_row("main_even",     WR,   25'h00004, 8'h3C, 32'h0002);
        add_row("main_odd",      WR,   25'h00005, 8'hA7, 32'h0002);
        add_row("scr_lo_even",   WR,   25'h08000, 8'h11, 32'h4001);
        add_row("scr_lo_odd",    WR,   25'h08001, 8'h22, 32'h4001);
        add_row("scr_hi_even",   WR,   25'h08010, 8'h33, 32'h4000);
        add_row("scr_hi_odd",    WR,   25'h08011, 8'h44, 32'h4000);
        add_row("obj_lo_even",   WR,   25'h10020, 8'h55, 32'h8001);
        add_row("obj_lo_odd",    WR,   25'h10021, 8'h66, 32'h8001);
        add_row("obj_hi_even",   WR,   25'h10030, 8'h77, 32'h8000);
        add_row("obj_hi_odd",    WR,   25'h10031, 8'h88, 32'h8000);
        add_row("prom_first",    WR,   25'h18000, 8'h12, 32'h000);
        add_row("flag_set",      WR,   25'h18001, 8'hFF, 32'h001);
        add_row("flag_clear",    WR,   25'h18001, 8'hF7, 32'h001);
        add_row("prom_last",     WR,   25'h187FF, 8'h9C, 32'h7FF);
        add_row("flag_again",    WR,   25'h18001, 8'hFF, 32'h001);
        add_row("scr_main_race", BOTH, 25'h00000, 8'h04, 32'h4000);
        add_row("obj_fetch",     OBJ,  25'h00000, 8'h00, 32'h8000);
        add_row("main_hit",      MAIN, 25'h00005, 8'h00, NO_REQ);
        add_row("scr_hit",       SCR,  25'h00000, 8'h00, NO_REQ);
        repeat (RST_CYC) @(posedge clk);
        #2 rst_n = 1'b1;
        check_value("reset_state", 0, {prog_we, prom_we, sdram_req, scr_ok, obj_ok,
                                       main_ok, alt_map});
        foreach (rows[i]) begin
            if (rows[i].kind == WR) begin
                write_byte(rows[i]);
            end else begin
                fetch_slot(rows[i]);
            end
        end
        if (u_dut.u_props.fail_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("A bound protocol assertion failed, see the error above");
            $display("Test FAILED");
            $fatal(1, "run stopped by a protocol assertion");
        end
    end

endmodule

//--- build.f
design/game_rom_pkg.sv
design/rom_dwnld.sv
design/rom_slot.sv
design/rom_arbiter.sv
design/game_rom_top.sv
test/sdram_model.sv
test/game_rom_properties.sv
test/tb_game_rom.sv
